//--- design/hdd_drive_pkg.sv
package hdd_drive_pkg;

    // ----------------------------------------
    // Drive-side widths
    // ----------------------------------------
    typedef logic [15:0] cyl_t;          // Cylinder number
    typedef logic [27:0] cycle_count_t;  // Index periods and seek times, in clocks

    // ----------------------------------------
    // Seek test sequence
    // ----------------------------------------
    localparam int NUM_SEEK_TESTS = 8;

    // Short, medium and long strokes, with two returns to track 0
    localparam cyl_t SEEK_TARGETS [NUM_SEEK_TESTS] = '{
        16'd10,   // Short
        16'd50,   // Medium
        16'd100,
        16'd300,  // Long
        16'd200,  // Back inward
        16'd0,    // Track 0
        16'd400,  // Longest stroke
        16'd0     // Home again
    };

    // ----------------------------------------
    // Timeouts, scaled by CLK_HZ in the RTL
    // ----------------------------------------
    localparam int INDEX_TIMEOUT_MS = 40;   // Slower than 1500 RPM means no rotation
    localparam int SEEK_TIMEOUT_MS  = 133;

    // Seek command to the drive
    typedef struct packed {
        logic start;  // One-cycle strobe
        cyl_t cyl;    // Target, valid with start
    } seek_cmd_t;

    // Seek response from the drive
    typedef struct packed {
        logic done;
        logic error;  // Qualified by done
    } seek_rsp_t;

endpackage

//--- design/hdd_health_pkg.sv
package hdd_health_pkg;

    // ----------------------------------------
    // Result widths
    // ----------------------------------------
    localparam int NUM_PERIODS = 8;  // Revolutions averaged

    typedef logic [15:0] rpm_t;         // RPM x10, 36000 = 3600 RPM
    typedef logic [7:0]  score_t;       // 0 worst, 255 best (jitter the other way)
    typedef logic [15:0] usec_t;
    typedef logic [31:0] sum_t;
    typedef logic [3:0]  seek_count_t;

    // Revolution summary from the RPM meter
    typedef struct packed {
        sum_t                       period_sum;
        hdd_drive_pkg::cycle_count_t period_min;
        hdd_drive_pkg::cycle_count_t period_max;
        logic                       no_rotation;  // Index timed out
    } rpm_summary_t;

    // Seek summary from the seek tester
    typedef struct packed {
        sum_t        time_sum;       // Successful seeks only
        seek_count_t valid_count;    // Seeks with a usable time
        seek_count_t success_count;
    } seek_summary_t;

    // Final result
    typedef struct packed {
        rpm_t   rpm_x10;
        score_t jitter;
        usec_t  avg_seek_us;
        score_t reliability;
        score_t health;
    } health_result_t;

    // ----------------------------------------
    // Scoring
    // ----------------------------------------
    localparam score_t JITTER_GOOD = 8'd10;
    localparam score_t JITTER_FAIR = 8'd30;
    localparam score_t JITTER_POOR = 8'd100;

    localparam score_t RPM_SCORE_GOOD = 8'd255;
    localparam score_t RPM_SCORE_FAIR = 8'd200;
    localparam score_t RPM_SCORE_POOR = 8'd128;
    localparam score_t RPM_SCORE_BAD  = 8'd64;

    // Check sequencer
    typedef enum logic [2:0] {
        IDLE,
        RPM_MEAS,
        SEEK_TEST,
        CALCULATE,
        DONE
    } check_state_t;

endpackage

//--- design/hdd_rpm_meter.sv
module hdd_rpm_meter #(
    parameter int unsigned CLK_HZ = 300_000_000
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         start_i,       // Strobe
    input  logic                         index_pulse_i,
    output logic                         done_o,        // Level, cleared by start_i
    output hdd_health_pkg::rpm_summary_t summary_o
);

    import hdd_drive_pkg::*;
    import hdd_health_pkg::*;

    // No index edge within this many clocks means a stopped spindle
    localparam cycle_count_t TIMEOUT_CYC =
        cycle_count_t'(64'(INDEX_TIMEOUT_MS) * CLK_HZ / 1000);

    typedef enum logic [1:0] {
        MEAS_IDLE,
        MEAS_ARM,   // Waiting for first edge
        MEAS_RUN    // Timing periods
    } meas_state_t;

    meas_state_t  state_q;
    logic         index_prev_q;
    logic         index_edge;
    cycle_count_t timer_q;     // Clocks since last edge, starts at 1
    logic [3:0]   periods_q;   // Periods captured so far

    assign index_edge = index_pulse_i && !index_prev_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q      <= MEAS_IDLE;
            done_o       <= 1'b0;
            index_prev_q <= 1'b0;
        end else begin
            index_prev_q <= index_pulse_i;
            timer_q      <= timer_q + 1'b1;

            case (state_q)
                MEAS_IDLE: begin
                    if (start_i) begin
                        done_o                <= 1'b0;
                        timer_q               <= cycle_count_t'(1);
                        periods_q             <= '0;
                        summary_o.period_sum  <= '0;
                        summary_o.period_min  <= '1;  // Any period beats this
                        summary_o.period_max  <= '0;
                        summary_o.no_rotation <= 1'b0;
                        state_q               <= MEAS_ARM;
                    end
                end

                MEAS_ARM, MEAS_RUN: begin
                    if (index_edge) begin
                        timer_q <= cycle_count_t'(1);  // Edge clock ends one period
                        state_q <= MEAS_RUN;
                        if (state_q == MEAS_RUN) begin
                            summary_o.period_sum <= summary_o.period_sum + sum_t'(timer_q);
                            if (timer_q < summary_o.period_min)
                                summary_o.period_min <= timer_q;
                            if (timer_q > summary_o.period_max)
                                summary_o.period_max <= timer_q;
                            periods_q <= periods_q + 1'b1;
                            if (periods_q == 4'(NUM_PERIODS - 1)) begin
                                done_o  <= 1'b1;  // Eighth period in
                                state_q <= MEAS_IDLE;
                            end
                        end
                    end else if (timer_q >= TIMEOUT_CYC) begin
                        summary_o.no_rotation <= 1'b1;
                        done_o                <= 1'b1;
                        state_q               <= MEAS_IDLE;
                    end
                end

                default: state_q <= MEAS_IDLE;
            endcase
        end
    end

endmodule

//--- design/hdd_seek_tester.sv
module hdd_seek_tester #(
    parameter int unsigned CLK_HZ = 300_000_000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_i,     // Strobe
    output hdd_drive_pkg::seek_cmd_t      seek_cmd_o,
    input  hdd_drive_pkg::seek_rsp_t      seek_rsp_i,
    output logic                          done_o,      // Level, cleared by start_i
    output hdd_health_pkg::seek_summary_t summary_o
);

    import hdd_drive_pkg::*;
    import hdd_health_pkg::*;

    localparam cycle_count_t TIMEOUT_CYC =
        cycle_count_t'(64'(SEEK_TIMEOUT_MS) * CLK_HZ / 1000);

    typedef enum logic [1:0] {
        SK_IDLE,
        SK_ISSUE,  // Launch next seek
        SK_WAIT    // Timing the drive
    } seek_state_t;

    seek_state_t  state_q;
    logic [2:0]   idx_q;       // Table position
    cycle_count_t timer_q;     // Clocks since the start cycle
    logic         timed_out;
    logic         finished;    // Result this cycle, good or bad
    logic         success;

    assign timed_out = timer_q >= TIMEOUT_CYC;
    assign finished  = seek_rsp_i.done || timed_out;
    // A response on the timeout clock still counts as a failure
    assign success   = seek_rsp_i.done && !seek_rsp_i.error && !timed_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q          <= SK_IDLE;
            done_o           <= 1'b0;
            seek_cmd_o.start <= 1'b0;
        end else begin
            seek_cmd_o.start <= 1'b0;  // Strobe by default

            case (state_q)
                SK_IDLE: begin
                    if (start_i) begin
                        done_o    <= 1'b0;
                        idx_q     <= '0;
                        summary_o <= '0;
                        state_q   <= SK_ISSUE;
                    end
                end

                SK_ISSUE: begin
                    seek_cmd_o.start <= 1'b1;
                    seek_cmd_o.cyl   <= SEEK_TARGETS[idx_q];
                    timer_q          <= '0;
                    state_q          <= SK_WAIT;
                end

                SK_WAIT: begin
                    timer_q <= timer_q + 1'b1;
                    if (finished) begin
                        if (success) begin
                            summary_o.time_sum      <= summary_o.time_sum + sum_t'(timer_q);
                            summary_o.valid_count   <= summary_o.valid_count + 1'b1;
                            summary_o.success_count <= summary_o.success_count + 1'b1;
                        end
                        idx_q <= idx_q + 1'b1;
                        // One idle clock, then the next launch
                        if (idx_q == 3'(NUM_SEEK_TESTS - 1)) begin
                            done_o  <= 1'b1;
                            state_q <= SK_IDLE;
                        end else begin
                            state_q <= SK_ISSUE;
                        end
                    end
                end

                default: state_q <= SK_IDLE;
            endcase
        end
    end

endmodule

//--- design/hdd_health_scorer.sv
module hdd_health_scorer #(
    parameter int unsigned CLK_HZ = 300_000_000
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           calc_i,   // Register new results
    input  logic                           fault_i,
    input  hdd_health_pkg::rpm_summary_t   rpm_i,
    input  hdd_health_pkg::seek_summary_t  seek_i,
    output hdd_health_pkg::health_result_t result_o
);

    import hdd_drive_pkg::*;
    import hdd_health_pkg::*;

    localparam longint unsigned RPM_NUM  = 64'd600 * CLK_HZ;  // 60 s x10 resolution
    localparam longint unsigned US_PER_S = 64'd1_000_000;

    sum_t        avg_period;
    logic [63:0] jitter_full;
    logic [63:0] seek_avg_cyc;
    logic [63:0] seek_us_full;
    logic [9:0]  health_sum;
    rpm_t        rpm_x10;
    score_t      jitter;
    usec_t       avg_seek_us;
    score_t      reliability;
    score_t      rpm_score;
    score_t      fault_score;

    // ----------------------------------------
    // Spindle
    // ----------------------------------------
    always_comb begin
        avg_period  = rpm_i.period_sum / NUM_PERIODS;
        jitter_full = '0;
        if (rpm_i.no_rotation || avg_period == '0) begin
            rpm_x10 = '0;
            jitter  = 8'd255;  // Worst case
        end else begin
            rpm_x10     = rpm_t'(RPM_NUM / 64'(avg_period));
            jitter_full = (64'(rpm_i.period_max - rpm_i.period_min) << 8) / 64'(avg_period);
            jitter      = (jitter_full > 64'd255) ? 8'd255 : score_t'(jitter_full);
        end

        // Uses this cycle's jitter
        if (jitter < JITTER_GOOD)
            rpm_score = RPM_SCORE_GOOD;
        else if (jitter < JITTER_FAIR)
            rpm_score = RPM_SCORE_FAIR;
        else if (jitter < JITTER_POOR)
            rpm_score = RPM_SCORE_POOR;
        else
            rpm_score = RPM_SCORE_BAD;
    end

    // ----------------------------------------
    // Seeks and overall score
    // ----------------------------------------
    always_comb begin
        seek_avg_cyc = '0;
        seek_us_full = '0;
        if (seek_i.valid_count == '0) begin
            avg_seek_us = 16'hFFFF;  // No usable seek
        end else begin
            seek_avg_cyc = 64'(seek_i.time_sum / sum_t'(seek_i.valid_count));
            seek_us_full = seek_avg_cyc * US_PER_S / CLK_HZ;
            avg_seek_us  = (seek_us_full > 64'd65534) ? 16'd65534 : usec_t'(seek_us_full);
        end

        reliability = score_t'((16'(seek_i.success_count) * 16'd255) / 16'(NUM_SEEK_TESTS));
        fault_score = fault_i ? 8'd0 : 8'd255;
        health_sum  = 10'(rpm_score) + 10'(reliability) + 10'(fault_score);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_o <= '0;
        end else if (calc_i) begin
            result_o.rpm_x10     <= rpm_x10;
            result_o.jitter      <= jitter;
            result_o.avg_seek_us <= avg_seek_us;
            result_o.reliability <= reliability;
            result_o.health      <= score_t'(health_sum / 10'd3);  // Equal weights
        end
    end

endmodule

//--- design/hdd_health_monitor.sv
module hdd_health_monitor #(
    parameter int unsigned CLK_HZ = 300_000_000
) (
    input  logic                           clk,
    input  logic                           reset,

    // Control
    input  logic                           check_start_i,  // Strobe, ignored while busy
    output logic                           check_busy_o,
    output logic                           check_done_o,   // One-cycle pulse

    // Drive
    input  logic                           index_pulse_i,
    input  logic                           drive_fault_i,
    output hdd_drive_pkg::seek_cmd_t       seek_cmd_o,
    input  hdd_drive_pkg::seek_rsp_t       seek_rsp_i,

    // Result, valid with check_done_o
    output hdd_health_pkg::health_result_t health_o
);

    import hdd_health_pkg::*;

    check_state_t  state_q;
    logic          rpm_start;
    logic          rpm_done;
    rpm_summary_t  rpm_summary;
    logic          seek_start;
    logic          seek_done;
    seek_summary_t seek_summary;
    logic          calc;

    // ----------------------------------------
    // Check sequencer
    // ----------------------------------------
    // Phase starts are decoded on the transition edge so that a done level
    // from the previous check is cleared before it can be sampled again
    assign rpm_start  = (state_q == IDLE) && check_start_i;
    assign seek_start = (state_q == RPM_MEAS) && rpm_done;
    assign calc       = (state_q == CALCULATE);  // health_o loads on this edge

    assign check_busy_o = (state_q != IDLE) && (state_q != DONE);
    assign check_done_o = (state_q == DONE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE:      if (check_start_i) state_q <= RPM_MEAS;
                RPM_MEAS:  if (rpm_done) state_q <= SEEK_TEST;
                SEEK_TEST: if (seek_done) state_q <= CALCULATE;
                CALCULATE: state_q <= DONE;
                DONE:      state_q <= IDLE;     // Busy already low here
                default:   state_q <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Phases
    // ----------------------------------------
    hdd_rpm_meter #(
        .CLK_HZ(CLK_HZ)
    ) hdd_rpm_meter_i (
        .clk          (clk),
        .reset        (reset),
        .start_i      (rpm_start),
        .index_pulse_i(index_pulse_i),
        .done_o       (rpm_done),
        .summary_o    (rpm_summary)
    );

    hdd_seek_tester #(
        .CLK_HZ(CLK_HZ)
    ) hdd_seek_tester_i (
        .clk       (clk),
        .reset     (reset),
        .start_i   (seek_start),
        .seek_cmd_o(seek_cmd_o),
        .seek_rsp_i(seek_rsp_i),
        .done_o    (seek_done),
        .summary_o (seek_summary)
    );

    hdd_health_scorer #(
        .CLK_HZ(CLK_HZ)
    ) hdd_health_scorer_i (
        .clk     (clk),
        .reset   (reset),
        .calc_i  (calc),
        .fault_i (drive_fault_i),  // Sampled at calc
        .rpm_i   (rpm_summary),
        .seek_i  (seek_summary),
        .result_o(health_o)
    );

endmodule

//--- dv/hdd_health_monitor_asserts.sv
module hdd_health_monitor_asserts (
    input logic clk,
    input logic reset,
    input logic check_start_i,
    input logic check_busy_i,
    input logic check_done_i,
    input logic seek_start_i
);

    // ----------------------------------------
    // Busy/done protocol
    // ----------------------------------------
    done_pulse_a: assert property (@(posedge clk) disable iff (reset)
        check_done_i |=> !check_done_i)  // Single-cycle pulse
        else $error("check_done held for more than one cycle");

    done_not_busy_a: assert property (@(posedge clk) disable iff (reset)
        !(check_done_i && check_busy_i))
        else $error("check_done and busy high together");

    // Idle means neither busy nor done
    start_busy_a: assert property (@(posedge clk) disable iff (reset)
        (check_start_i && !check_busy_i && !check_done_i) |=> check_busy_i)
        else $error("busy did not follow a start in idle");

    // ----------------------------------------
    // Seek command strobe
    // ----------------------------------------
    seek_pulse_a: assert property (@(posedge clk) disable iff (reset)
        seek_start_i |=> !seek_start_i)
        else $error("seek start held for more than one cycle");

    seek_in_busy_a: assert property (@(posedge clk) disable iff (reset)
        seek_start_i |-> check_busy_i)  // Seeks only inside a check
        else $error("seek start outside a check");

endmodule

bind hdd_health_monitor hdd_health_monitor_asserts hdd_health_monitor_asserts_i (
    .clk          (clk),
    .reset        (reset),
    .check_start_i(check_start_i),
    .check_busy_i (check_busy_o),
    .check_done_i (check_done_o),
    .seek_start_i (seek_cmd_o.start)
);

//--- dv/hdd_health_monitor_tb.sv
module hdd_health_monitor_tb;

    import hdd_drive_pkg::*;
    import hdd_health_pkg::*;

    localparam int unsigned CLK_HZ        = 30_000;  // Scaled down so timeouts stay short
    localparam int          NUM_TESTS     = 5;
    localparam int          CHECK_TIMEOUT = 50_000;   // Clocks allowed per check
    localparam int          QUIET_CYCLES  = 20;       // Watched after done

    // One stimulus row
    typedef struct packed {
        logic [15:0] period;     // Base index period in clocks
        logic [15:0] delta;      // Alternating +/- on the period
        logic        spin;       // Index pulses present
        logic [15:0] seek_base;  // Seek duration before random offset
        logic [7:0]  err_mask;   // Seeks answered with error
        logic [7:0]  tmo_mask;   // Seeks never answered
        logic        fault;
    } test_row_t;

    localparam test_row_t TESTS [NUM_TESTS] = '{
        '{16'd500, 16'd0,  1'b1, 16'd60,  8'h00, 8'h00, 1'b0},
        '{16'd600, 16'd45, 1'b1, 16'd80,  8'h00, 8'h00, 1'b0},
        '{16'd500, 16'd5,  1'b1, 16'd120, 8'h24, 8'h08, 1'b0},  // Seek 3 times out
        '{16'd500, 16'd0,  1'b0, 16'd40,  8'hFF, 8'h00, 1'b0},
        '{16'd450, 16'd10, 1'b1, 16'd70,  8'h00, 8'h00, 1'b1}
    };
    string TEST_NAMES [NUM_TESTS] = '{"steady", "jitter", "seek_errors", "no_spin", "fault"};

    // Cylinders the drive should see in order
    localparam int EXPECTED_CYLS [NUM_SEEK_TESTS] = '{10, 50, 100, 300, 200, 0, 400, 0};

    logic           clk = 1'b0;
    logic           reset;
    logic           check_start_i;
    logic           check_busy_o;
    logic           check_done_o;
    logic           index_pulse_i = 1'b0;
    logic           drive_fault_i;
    seek_cmd_t      seek_cmd_o;
    seek_rsp_t      seek_rsp_i = '0;
    health_result_t health_o;

    test_row_t cur_row = '0;
    int        errors  = 0;

    // Index model state
    int spin_gen   = 0;  // Bumped per row to restart the model
    int spin_seen  = 0;
    int spin_count = 0;
    bit spin_long  = 1'b1;

    // Seek responder state and its record of each seek
    int   seek_n     = 0;
    int   seek_slot  = 0;
    int   seek_count = 0;
    int   seek_wait  = 0;
    bit   seek_busy  = 1'b0;
    int   seek_ofs [NUM_SEEK_TESTS];  // Random spread per seek, drawn per row
    int   seek_cyc [NUM_SEEK_TESTS];
    cyl_t seen_cyl [NUM_SEEK_TESTS];

    always #4 clk = ~clk;

    hdd_health_monitor #(
        .CLK_HZ(CLK_HZ)
    ) hdd_health_monitor_i (
        .clk          (clk),
        .reset        (reset),
        .check_start_i(check_start_i),
        .check_busy_o (check_busy_o),
        .check_done_o (check_done_o),
        .index_pulse_i(index_pulse_i),
        .drive_fault_i(drive_fault_i),
        .seek_cmd_o   (seek_cmd_o),
        .seek_rsp_i   (seek_rsp_i),
        .health_o     (health_o)
    );

    // ----------------------------------------
    // Drive models
    // ----------------------------------------
    // One-cycle index pulse with spacing alternating long and short
    always begin : index_model
        @(posedge clk);
        #1;
        index_pulse_i = 1'b0;
        if (spin_gen != spin_seen) begin
            spin_seen  = spin_gen;  // Fresh phase for the new row
            spin_count = 0;
            spin_long  = 1'b1;
        end else if (cur_row.spin) begin
            spin_count++;
            if (spin_count >= (spin_long ? int'(cur_row.period + cur_row.delta)
                                         : int'(cur_row.period - cur_row.delta))) begin
                index_pulse_i = 1'b1;
                spin_count    = 0;
                spin_long     = !spin_long;
            end
        end
    end

    // Answers each seek after a counted delay or stays silent
    always begin : seek_responder
        @(posedge clk);
        #1;
        seek_rsp_i = '0;
        if (seek_cmd_o.start) begin
            seek_slot  = seek_n;
            seek_count = 0;
            seek_busy  = 1'b1;
            seek_wait  = int'(cur_row.seek_base);
            if (seek_n < NUM_SEEK_TESTS) begin
                seek_wait        = seek_wait + seek_ofs[seek_n];
                seen_cyl[seek_n] = seek_cmd_o.cyl;
                seek_cyc[seek_n] = seek_wait;  // Clocks from start to done sample
            end
            seek_n++;
        end else if (seek_busy) begin
            seek_count++;
            if (seek_count == seek_wait) begin
                seek_busy = 1'b0;
                if (seek_slot < NUM_SEEK_TESTS && !cur_row.tmo_mask[seek_slot]) begin
                    seek_rsp_i.done  = 1'b1;
                    seek_rsp_i.error = cur_row.err_mask[seek_slot];
                end
            end
        end
    end

    // ----------------------------------------
    // Reference model and checks
    // ----------------------------------------
    function automatic health_result_t model_result(test_row_t row);
        longint         pmin;
        longint         pmax;
        longint         avg;
        longint         jit;
        longint         t_sum;
        longint         us;
        int             n_ok;
        int             rpm_pts;
        int             fault_pts;
        health_result_t r;
        r     = '0;
        t_sum = 0;
        n_ok  = 0;
        if (row.spin) begin
            pmax      = longint'(row.period) + longint'(row.delta);
            pmin      = longint'(row.period) - longint'(row.delta);
            avg       = (4 * pmax + 4 * pmin) / 8;  // Any 8 periods hold 4 long and 4 short
            r.rpm_x10 = rpm_t'(600 * longint'(CLK_HZ) / avg);
            jit       = (pmax - pmin) * 256 / avg;
            r.jitter  = (jit > 255) ? 8'd255 : score_t'(jit);
        end else begin
            r.rpm_x10 = '0;
            r.jitter  = 8'd255;
        end
        for (int i = 0; i < NUM_SEEK_TESTS; i++) begin
            if (!row.err_mask[i] && !row.tmo_mask[i]) begin
                n_ok++;
                t_sum += seek_cyc[i];
            end
        end
        if (n_ok == 0) begin
            r.avg_seek_us = 16'hFFFF;
        end else begin
            us            = (t_sum / n_ok) * 1_000_000 / longint'(CLK_HZ);
            r.avg_seek_us = (us > 65534) ? 16'd65534 : usec_t'(us);
        end
        r.reliability = score_t'(n_ok * 255 / 8);
        if (r.jitter < 10)       rpm_pts = 255;
        else if (r.jitter < 30)  rpm_pts = 200;
        else if (r.jitter < 100) rpm_pts = 128;
        else                     rpm_pts = 64;
        fault_pts = row.fault ? 0 : 255;
        r.health  = score_t'((rpm_pts + int'(r.reliability) + fault_pts) / 3);
        return r;
    endfunction

    task automatic check_value(string test, string field, longint expected, longint actual);
        if (expected != actual) begin
            errors++;
            $display("mismatch %0s %0s: expected %0d actual %0d", test, field, expected, actual);
        end
    endtask

    task automatic report_error(string test, string what);
        errors++;
        $display("error %0s: %0s", test, what);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;  // Drive and sample away from the edge
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : main
        health_result_t exp;
        int             cycles;
        int             errs_before;
        int             failed;
        int             run;
        bit             aborted;
        failed  = 0;
        run     = 0;
        aborted = 1'b0;
        void'($urandom(99));
        reset         = 1'b1;
        check_start_i = 1'b0;
        drive_fault_i = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        for (int t = 0; t < NUM_TESTS && !aborted; t++) begin
            errs_before   = errors;
            cur_row       = TESTS[t];
            drive_fault_i = cur_row.fault;
            seek_n        = 0;
            for (int i = 0; i < NUM_SEEK_TESTS; i++)
                seek_ofs[i] = int'($urandom % 8);  // Small per-seek duration spread
            spin_gen++;
            next_cycle();
            check_start_i = 1'b1;
            next_cycle();
            check_start_i = 1'b0;
            if (!check_busy_o)
                report_error(TEST_NAMES[t], "busy did not rise after start");

            cycles = 0;
            while (!check_done_o && cycles < CHECK_TIMEOUT) begin
                check_start_i = (cycles == 20);  // Stray start while busy
                next_cycle();
                cycles++;
            end
            check_start_i = 1'b0;
            run++;

            if (!check_done_o) begin
                report_error(TEST_NAMES[t], "check_done never came, run stopped");
                aborted = 1'b1;
            end else begin
                exp = model_result(cur_row);
                check_value(TEST_NAMES[t], "rpm_x10", exp.rpm_x10, health_o.rpm_x10);
                check_value(TEST_NAMES[t], "jitter", exp.jitter, health_o.jitter);
                check_value(TEST_NAMES[t], "avg_seek_us", exp.avg_seek_us, health_o.avg_seek_us);
                check_value(TEST_NAMES[t], "reliability", exp.reliability, health_o.reliability);
                check_value(TEST_NAMES[t], "health", exp.health, health_o.health);
                check_value(TEST_NAMES[t], "seek_count", NUM_SEEK_TESTS, seek_n);
                for (int i = 0; i < NUM_SEEK_TESTS && i < seek_n; i++)
                    check_value(TEST_NAMES[t], "cyl", EXPECTED_CYLS[i], seen_cyl[i]);
                if (check_busy_o)
                    report_error(TEST_NAMES[t], "busy still high with done");
                // The stray start must not have queued a second check
                for (int i = 0; i < QUIET_CYCLES; i++) begin
                    next_cycle();
                    if (check_done_o)
                        report_error(TEST_NAMES[t], "done pulsed more than once");
                    if (check_busy_o)
                        report_error(TEST_NAMES[t], "busy rose without a start");
                end
            end

            if (errors != errs_before)
                failed++;
            $display("test %0s: %0s", TEST_NAMES[t], (errors == errs_before) ? "ok" : "FAILED");
        end

        $display("tests run %0d, failed %0d, errors %0d", run, failed, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- hdd_health_monitor.f
design/hdd_drive_pkg.sv
design/hdd_health_pkg.sv
design/hdd_rpm_meter.sv
design/hdd_seek_tester.sv
design/hdd_health_scorer.sv
design/hdd_health_monitor.sv
dv/hdd_health_monitor_asserts.sv
dv/hdd_health_monitor_tb.sv

//--- Bender.yml
package:
  name: hdd_health_monitor

sources:
  # Packages first, then RTL bottom-up
  - design/hdd_drive_pkg.sv
  - design/hdd_health_pkg.sv
  - design/hdd_rpm_meter.sv
  - design/hdd_seek_tester.sv
  - design/hdd_health_scorer.sv
  - design/hdd_health_monitor.sv

  # Testbench
  - target: test
    files:
      - dv/hdd_health_monitor_asserts.sv
      - dv/hdd_health_monitor_tb.sv
